// File: verilog/pow5_pkg.sv
package pow5_pkg;

    // --------------------
    // widths with a meaning

    typedef logic [2:0]  exp_t;
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] cnt_t;

    // legal exponent range
    localparam exp_t EXP_MIN = 3'd1;
    localparam exp_t EXP_MAX = 3'd5;

    // --------------------
    // register map

    localparam reg_addr_t ADDR_CTRL     = 2'd0;
    localparam reg_addr_t ADDR_RES_CNT  = 2'd1;
    localparam reg_addr_t ADDR_DROP_CNT = 2'd2;

    // control register fields, other bits read as zero
    localparam int CTRL_EXP_LSB = 0;
    localparam int CTRL_SEL_BIT = 3;

    // engine select encoding
    localparam logic ENG_PIPE = 1'b0;
    localparam logic ENG_ITER = 1'b1;

    // iterative engine FSM
    typedef enum logic
    {
        IDLE,
        MULT
    } iter_state_t;

endpackage

// File: verilog/pow_cfg_if.sv
`timescale 1ns/1ps

interface pow_cfg_if;

    // configuration, from the register block
    pow5_pkg::exp_t exponent;
    logic           engine_sel;

    // single-cycle events, back to the counters
    logic           res_event;
    logic           drop_event;

    modport regs
    (
        output exponent,
        output engine_sel,
        input  res_event,
        input  drop_event
    );

    // shared by the iterative engine and the result select
    modport engine
    (
        input  exponent,
        input  engine_sel,
        output res_event,
        output drop_event
    );

endinterface

// File: verilog/pow_cfg_regs.sv
`timescale 1ns/1ps

module pow_cfg_regs
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_clk_en,
    input  logic                i_cfg_wr,
    input  pow5_pkg::reg_addr_t i_cfg_addr,
    input  logic [31:0]         i_cfg_wdata,
    output logic [31:0]         o_cfg_rdata,
    pow_cfg_if.regs             cfg
);

    pow5_pkg::exp_t wr_exp;
    logic           exp_ok;
    logic           wr_ctrl;
    logic           clr_res;
    logic           clr_drop;

    pow5_pkg::exp_t exp_q;
    logic           sel_q;
    pow5_pkg::cnt_t res_cnt;
    pow5_pkg::cnt_t drop_cnt;

    // counters stick at all ones
    function automatic pow5_pkg::cnt_t sat_inc(input pow5_pkg::cnt_t value);
        if (value == '1)
            return value;
        return value + 1'b1;
    endfunction

    // --------------------
    // write decode

    assign wr_exp   = i_cfg_wdata[pow5_pkg::CTRL_EXP_LSB +: $bits(pow5_pkg::exp_t)];
    assign exp_ok   = (wr_exp >= pow5_pkg::EXP_MIN) && (wr_exp <= pow5_pkg::EXP_MAX);
    assign wr_ctrl  = i_cfg_wr && (i_cfg_addr == pow5_pkg::ADDR_CTRL) && exp_ok;
    assign clr_res  = i_cfg_wr && (i_cfg_addr == pow5_pkg::ADDR_RES_CNT);
    assign clr_drop = i_cfg_wr && (i_cfg_addr == pow5_pkg::ADDR_DROP_CNT);

    // bad exponent drops the whole write, select bit included
    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            exp_q <= pow5_pkg::EXP_MAX;
            sel_q <= pow5_pkg::ENG_PIPE;
        end
        else if (i_clk_en && wr_ctrl)
        begin
            exp_q <= wr_exp;
            sel_q <= i_cfg_wdata[pow5_pkg::CTRL_SEL_BIT];
        end

    assign cfg.exponent   = exp_q;
    assign cfg.engine_sel = sel_q;

    // --------------------
    // event counters, a clear wins over a count

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            res_cnt  <= '0;
            drop_cnt <= '0;
        end
        else if (i_clk_en)
        begin
            if (clr_res)
                res_cnt <= '0;
            else if (cfg.res_event)
                res_cnt <= sat_inc(res_cnt);

            if (clr_drop)
                drop_cnt <= '0;
            else if (cfg.drop_event)
                drop_cnt <= sat_inc(drop_cnt);
        end

    // read mux
    always_comb
    begin
        o_cfg_rdata = '0;
        case (i_cfg_addr)
            pow5_pkg::ADDR_CTRL:
            begin
                o_cfg_rdata[pow5_pkg::CTRL_EXP_LSB +: $bits(pow5_pkg::exp_t)] = exp_q;
                o_cfg_rdata[pow5_pkg::CTRL_SEL_BIT] = sel_q;
            end
            pow5_pkg::ADDR_RES_CNT:  o_cfg_rdata = 32'(res_cnt);
            pow5_pkg::ADDR_DROP_CNT: o_cfg_rdata = 32'(drop_cnt);
            default:                 o_cfg_rdata = '0;
        endcase
    end

endmodule

// File: verilog/pow_pipeline.sv
`timescale 1ns/1ps

module pow_pipeline
#(
    parameter int W = 8
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_clk_en,
    input  logic             i_n_vld,
    input  logic [W-1:0]     i_n,
    output logic [4:0]       o_stage_vld,
    output logic [5*W-1:0]   o_pow
);

    // stage k holds n^(k+1)
    logic         vld_q  [5];
    logic [W-1:0] pow_q  [5];
    // operand copy for all but the last stage
    logic [W-1:0] opnd_q [4];

    genvar k;

    generate
        for (k = 0; k < 5; k++)
        begin : g_stage
            logic         in_vld;
            logic [W-1:0] in_n;
            logic [W-1:0] nxt_pow;

            // --------------------
            // stage inputs

            if (k == 0)
            begin : g_head
                assign in_vld  = i_n_vld;
                assign in_n    = i_n;
                // n^1 is the operand itself
                assign nxt_pow = i_n;
            end
            else
            begin : g_body
                assign in_vld  = vld_q[k-1];
                assign in_n    = opnd_q[k-1];
                assign nxt_pow = pow_q[k-1] * in_n;
            end

            always_ff @(posedge clk or negedge rst_n)
                if (!rst_n)
                    vld_q[k] <= 1'b0;
                else if (i_clk_en)
                    vld_q[k] <= in_vld;

            always_ff @(posedge clk)
                if (i_clk_en)
                    pow_q[k] <= nxt_pow;

            if (k < 4)
            begin : g_pass
                always_ff @(posedge clk)
                    if (i_clk_en)
                        opnd_q[k] <= in_n;
            end

            assign o_stage_vld[k]   = vld_q[k];
            assign o_pow[k*W +: W] = pow_q[k];
        end
    endgenerate

endmodule

// File: verilog/pow_iterative.sv
`timescale 1ns/1ps

module pow_iterative
#(
    parameter int W = 8
)
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_clk_en,
    input  logic         i_n_vld,
    input  logic [W-1:0] i_n,
    pow_cfg_if.engine    cfg,
    output logic         o_done,
    output logic [W-1:0] o_res
);

    pow5_pkg::iter_state_t state;
    pow5_pkg::exp_t        step;
    logic [W-1:0]          opnd_q;
    logic [W-1:0]          acc_q;
    logic [W-1:0]          prod;
    logic                  strobe;
    logic                  busy;

    // only listens while selected
    assign strobe = i_clk_en && i_n_vld && (cfg.engine_sel == pow5_pkg::ENG_ITER);
    assign busy   = (state == pow5_pkg::MULT);

    // operand refused while a power is in progress
    assign cfg.drop_event = strobe && busy;

    // the one multiplier
    assign prod  = acc_q * opnd_q;
    assign o_res = acc_q;

    // --------------------
    // control FSM

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            state  <= pow5_pkg::IDLE;
            step   <= '0;
            o_done <= 1'b0;
        end
        else if (i_clk_en)
        begin
            o_done <= 1'b0;
            case (state)
                pow5_pkg::IDLE:
                    if (strobe)
                    begin
                        // n^1 is ready right after the load
                        if (cfg.exponent == pow5_pkg::EXP_MIN)
                            o_done <= 1'b1;
                        else
                        begin
                            state <= pow5_pkg::MULT;
                            step  <= cfg.exponent - 1'b1;
                        end
                    end
                pow5_pkg::MULT:
                begin
                    step <= step - 1'b1;
                    if (step == pow5_pkg::exp_t'(1))
                    begin
                        state  <= pow5_pkg::IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= pow5_pkg::IDLE;
            endcase
        end

    // datapath
    always_ff @(posedge clk)
        if (i_clk_en)
        begin
            if (!busy && strobe)
            begin
                acc_q  <= i_n;
                opnd_q <= i_n;
            end
            else if (busy)
                acc_q <= prod;
        end

endmodule

// File: verilog/pow_result_sel.sv
`timescale 1ns/1ps

module pow_result_sel
#(
    parameter int W = 8
)
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_clk_en,
    input  logic [4:0]     i_stage_vld,
    input  logic [5*W-1:0] i_pow,
    input  logic           i_iter_done,
    input  logic [W-1:0]   i_iter_res,
    pow_cfg_if.engine      cfg,
    output logic           o_res_vld,
    output logic [W-1:0]   o_res
);

    pow5_pkg::exp_t tap;
    logic           sel_vld;
    logic [W-1:0]   sel_res;

    // stage index of n^e
    assign tap = cfg.exponent - 1'b1;

    always_comb
    begin
        if (cfg.engine_sel == pow5_pkg::ENG_ITER)
        begin
            sel_vld = i_iter_done;
            sel_res = i_iter_res;
        end
        else
        begin
            sel_vld = i_stage_vld[tap];
            sel_res = i_pow[tap*W +: W];
        end
    end

    // --------------------
    // output register

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            o_res_vld <= 1'b0;
        else if (i_clk_en)
            o_res_vld <= sel_vld;

    always_ff @(posedge clk)
        if (i_clk_en)
            o_res <= sel_res;

    // one count per delivered result
    assign cfg.res_event = o_res_vld;

endmodule

// File: verilog/pow5_top.sv
`timescale 1ns/1ps

module pow5_top
#(
    parameter int W = 8
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_clk_en,
    input  logic                i_n_vld,
    input  logic [W-1:0]        i_n,
    input  logic                i_cfg_wr,
    input  pow5_pkg::reg_addr_t i_cfg_addr,
    input  logic [31:0]         i_cfg_wdata,
    output logic [31:0]         o_cfg_rdata,
    output logic                o_res_vld,
    output logic [W-1:0]        o_res
);

    logic [4:0]     stage_vld;
    logic [5*W-1:0] pow_taps;
    logic           iter_done;
    logic [W-1:0]   iter_res;

    pow_cfg_if cfg ();

    // --------------------
    // configuration and counters

    pow_cfg_regs i_regs
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_clk_en    (i_clk_en),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .cfg         (cfg.regs)
    );

    // --------------------
    // the two engines, side by side

    pow_pipeline #(.W(W)) i_pipe
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_clk_en    (i_clk_en),
        .i_n_vld     (i_n_vld),
        .i_n         (i_n),
        .o_stage_vld (stage_vld),
        .o_pow       (pow_taps)
    );

    pow_iterative #(.W(W)) i_iter
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_clk_en (i_clk_en),
        .i_n_vld  (i_n_vld),
        .i_n      (i_n),
        .cfg      (cfg.engine),
        .o_done   (iter_done),
        .o_res    (iter_res)
    );

    // result select and output register
    pow_result_sel #(.W(W)) i_sel
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_clk_en    (i_clk_en),
        .i_stage_vld (stage_vld),
        .i_pow       (pow_taps),
        .i_iter_done (iter_done),
        .i_iter_res  (iter_res),
        .cfg         (cfg.engine),
        .o_res_vld   (o_res_vld),
        .o_res       (o_res)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: bench/pow5_assert.sv
`timescale 1ns/1ps

module pow5_assert
(
    input logic           clk,
    input logic           rst_n,
    input logic           i_clk_en,
    input logic           i_n_vld,
    input logic           o_res_vld,
    input logic           engine_sel,
    input pow5_pkg::exp_t exponent,
    input logic           iter_busy
);

    // pipelined strobes, one bit per enabled cycle
    logic [5:0] pipe_sr;
    int         busy_run;

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            pipe_sr <= '0;
        else if (i_clk_en)
            pipe_sr <= {pipe_sr[4:0], i_n_vld && (engine_sel == pow5_pkg::ENG_PIPE)};

    // enabled cycles spent in MULT
    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            busy_run <= 0;
        else if (!iter_busy)
            busy_run <= 0;
        else if (i_clk_en)
            busy_run <= busy_run + 1;

    a_vld_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(o_res_vld))
        else $error("o_res_vld is unknown");

    a_pipe_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (engine_sel == pow5_pkg::ENG_PIPE && pipe_sr[exponent]) |-> o_res_vld)
        else $error("pipelined result missing exponent+1 cycles after the strobe");

    a_iter_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_run <= 5)
        else $error("iterative engine busy for more than 5 cycles");

endmodule

bind pow5_top pow5_assert i_assert
(
    .clk        (clk),
    .rst_n      (rst_n),
    .i_clk_en   (i_clk_en),
    .i_n_vld    (i_n_vld),
    .o_res_vld  (o_res_vld),
    .engine_sel (cfg.engine_sel),
    .exponent   (cfg.exponent),
    .iter_busy  (i_iter.busy)
);

// File: bench/pow5_tb.sv
`timescale 1ns/1ps

module pow5_tb;

    localparam int W          = 8;
    localparam int PIPE       = 0;
    localparam int ITER       = 1;
    localparam int RND        = -1;
    localparam int N_STIM     = 32;
    localparam int RST_CYCLES = 16;

    // engine, exponent, operand, idle cycles after, clock enable hold
    typedef struct packed
    {
        int eng;
        int exp;
        int opnd;
        int gap;
        int hold;
    } stim_t;

    stim_t stim_tab [N_STIM] = '{
        '{PIPE, 1, 7, 0, 0}, '{PIPE, 1, RND, 0, 0}, '{PIPE, 1, 255, 0, 0},
        '{PIPE, 2, RND, 0, 0}, '{PIPE, 2, 16, 0, 0}, '{PIPE, 3, RND, 0, 0},
        '{PIPE, 3, 6, 0, 0}, '{PIPE, 4, 3, 0, 0}, '{PIPE, 4, RND, 0, 0},
        '{PIPE, 5, 2, 0, 0}, '{PIPE, 5, RND, 0, 0}, '{PIPE, 5, RND, 0, 0},
        // bad exponents leave the old one for the operand
        '{PIPE, 6, 5, 0, 0}, '{PIPE, 0, RND, 0, 0}, '{PIPE, 5, RND, 0, 4},
        '{PIPE, 5, RND, 0, 0},
        '{ITER, 1, 9, 2, 0}, '{ITER, 2, RND, 3, 0}, '{ITER, 3, RND, 4, 0},
        '{ITER, 4, 3, 5, 0}, '{ITER, 5, RND, 6, 0},
        // back to back strobes while busy get dropped
        '{ITER, 4, RND, 0, 0}, '{ITER, 4, RND, 0, 0}, '{ITER, 4, RND, 0, 0},
        '{ITER, 4, RND, 0, 0}, '{ITER, 3, RND, 0, 0}, '{ITER, 3, RND, 0, 0},
        '{ITER, 5, RND, 0, 6}, '{ITER, 5, RND, 0, 0}, '{ITER, 7, RND, 6, 0},
        '{PIPE, 2, RND, 0, 0}, '{PIPE, 2, RND, 0, 0}
    };

    logic                clk;
    logic                rst_n;
    logic                i_clk_en;
    logic                i_n_vld;
    logic [W-1:0]        i_n;
    logic                i_cfg_wr;
    pow5_pkg::reg_addr_t i_cfg_addr;
    logic [31:0]         i_cfg_wdata;
    logic [31:0]         o_cfg_rdata;
    logic                o_res_vld;
    logic [W-1:0]        o_res;

    logic [W-1:0] want_q [$];
    logic [W-1:0] want;
    logic [31:0]  rd;
    stim_t        s;
    int           seed = 25;
    int           errors = 0;
    int           res_seen = 0;
    int           res_due = 0;
    int           drops = 0;
    int           busy_left = 0;
    int           cur_eng;
    int           cur_exp;
    int           n;
    int           idx;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RST_CYCLES)) i_clk_gen
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pow5_top #(.W(W)) i_dut
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_clk_en    (i_clk_en),
        .i_n_vld     (i_n_vld),
        .i_n         (i_n),
        .i_cfg_wr    (i_cfg_wr),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .o_res_vld   (o_res_vld),
        .o_res       (o_res)
    );

    // --------------------
    // reference model

    function automatic logic [W-1:0] power_ref(input int base, input int e);
        int acc;
        acc = 1;
        repeat (e)
            acc = (acc * base) % (1 << W);
        return W'(acc);
    endfunction

    function automatic logic [31:0] ctrl_word(input int eng, input int e);
        return (eng << 3) | e;
    endfunction

    // what the DUT does with the slot sampled at the next enabled edge
    task automatic account_slot(input bit strobe, input int value);
        if (cur_eng == ITER && busy_left > 0)
        begin
            busy_left--;
            if (strobe)
                drops++;
        end
        else if (strobe)
        begin
            want_q.push_back(power_ref(value, cur_exp));
            res_due++;
            if (cur_eng == ITER)
                busy_left = cur_exp - 1;
        end
    endtask

    // --------------------
    // stimulus

    task automatic tick(input bit strobe, input int value);
        @(posedge clk);
        i_clk_en <= 1'b1;
        i_n_vld  <= strobe;
        i_n      <= W'(value);
        i_cfg_wr <= 1'b0;
        account_slot(strobe, value);
    endtask

    task automatic write_reg(input pow5_pkg::reg_addr_t addr, input logic [31:0] data);
        tick(1'b0, 0);
        i_cfg_wr    <= 1'b1;
        i_cfg_addr  <= addr;
        i_cfg_wdata <= data;
        tick(1'b0, 0);
    endtask

    task automatic check_reg(input pow5_pkg::reg_addr_t addr, input logic [31:0] exp_val,
                             input string what);
        tick(1'b0, 0);
        i_cfg_addr <= addr;
        @(negedge clk);
        rd = o_cfg_rdata;
        if (rd !== exp_val)
        begin
            errors++;
            $display("FAILED at %0t ns: %s reads %0h, expected %0h", $time, what, rd, exp_val);
        end
    endtask

    // wait for both engines to go idle and the pipeline to flush
    task automatic drain();
        while (want_q.size() != 0 || busy_left != 0)
            tick(1'b0, 0);
        repeat (6) tick(1'b0, 0);
    endtask

    task automatic try_bad_exp(input int e);
        drain();
        write_reg(pow5_pkg::ADDR_CTRL, ctrl_word(1 - cur_eng, e));
        check_reg(pow5_pkg::ADDR_CTRL, ctrl_word(cur_eng, cur_exp), "control after bad write");
    endtask

    task automatic hold_clock(input int cycles);
        logic         vld_hold;
        logic [W-1:0] res_hold;
        @(posedge clk);
        i_clk_en <= 1'b0;
        // a strobe while frozen is ignored
        i_n_vld  <= 1'b1;
        i_n      <= '1;
        @(negedge clk);
        vld_hold = o_res_vld;
        res_hold = o_res;
        repeat (cycles)
        begin
            @(negedge clk);
            if (o_res_vld !== vld_hold || o_res !== res_hold)
            begin
                errors++;
                $display("FAILED at %0t ns: output moved with clock enable low", $time);
            end
        end
    endtask

    // --------------------
    // result monitor pops one entry per enabled valid

    always @(posedge clk)
    begin
        if (rst_n && i_clk_en && o_res_vld)
        begin
            res_seen++;
            if (want_q.size() == 0)
            begin
                errors++;
                $display("unexpected result %0h at %0t ns with no operand pending", o_res, $time);
            end
            else
            begin
                want = want_q.pop_front();
                if (o_res !== want)
                begin
                    errors++;
                    $display("FAILED at %0t ns: result %0h, expected %0h", $time, o_res, want);
                end
            end
        end
    end

    initial
    begin
        repeat (RST_CYCLES + N_STIM * 10) @(posedge clk);
        $display("timeout, the test did not finish within %0d cycles", RST_CYCLES + N_STIM * 10);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        i_clk_en    = 1'b1;
        i_n_vld     = 1'b0;
        i_n         = '0;
        i_cfg_wr    = 1'b0;
        i_cfg_addr  = pow5_pkg::ADDR_CTRL;
        i_cfg_wdata = '0;
        cur_eng     = PIPE;
        cur_exp     = 5;
        @(posedge rst_n);
        check_reg(pow5_pkg::ADDR_CTRL, ctrl_word(PIPE, 5), "control after reset");

        for (idx = 0; idx < N_STIM; idx++)
        begin
            s = stim_tab[idx];
            if (s.exp < 1 || s.exp > 5)
                try_bad_exp(s.exp);
            else if (s.eng != cur_eng || s.exp != cur_exp)
            begin
                drain();
                write_reg(pow5_pkg::ADDR_CTRL, ctrl_word(s.eng, s.exp));
                cur_eng = s.eng;
                cur_exp = s.exp;
            end
            n = (s.opnd == RND) ? ($random(seed) & ((1 << W) - 1)) : s.opnd;
            tick(1'b1, n);
            repeat (s.gap) tick(1'b0, 0);
            if (s.hold > 0)
                hold_clock(s.hold);
        end

        drain();
        check_reg(pow5_pkg::ADDR_RES_CNT, res_due, "result counter");
        check_reg(pow5_pkg::ADDR_DROP_CNT, drops, "drop counter");
        write_reg(pow5_pkg::ADDR_RES_CNT, '0);
        write_reg(pow5_pkg::ADDR_DROP_CNT, '0);
        check_reg(pow5_pkg::ADDR_RES_CNT, '0, "cleared result counter");
        check_reg(pow5_pkg::ADDR_DROP_CNT, '0, "cleared drop counter");

        $display("%0d results, %0d drops, %0d errors", res_seen, drops, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: pow5.f
verilog/pow5_pkg.sv
verilog/pow_cfg_if.sv
verilog/pow_cfg_regs.sv
verilog/pow_pipeline.sv
verilog/pow_iterative.sv
verilog/pow_result_sel.sv
verilog/pow5_top.sv
bench/tb_clock_gen.sv
bench/pow5_assert.sv
bench/pow5_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the pow5 testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pow5_tb -f pow5.f > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vpow5_tb > sim.log 2>&1

grep -q "Test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log \
    || { echo "simulation stopped early, see sim.log"; exit 1; }
echo "simulation passed"
